// File: common/ppu_bg_pkg.sv
// Shared types and constants for the background tile path; nametable mirroring is not modelled, so all four nametables are distinct
`default_nettype none

package ppu_bg_pkg;

	// One byte address in the 64 KiB video memory space
	typedef logic [15:0] vram_addr_t;

	// One data byte read from video memory
	typedef logic [7:0] vram_byte_t;

	// Pattern colour, high plane bit in bit 1 and low plane bit in bit 0
	typedef logic [1:0] pixel_color_t;

	// Pixel position inside one 8x8 tile
	typedef logic [2:0] fine_t;

	// Screen pixel request address, row 0-239 and column 0-255
	typedef struct packed {
		logic [7:0] screen_row;
		logic [7:0] screen_col;
	} pixel_coord_t;

	// Scroll position and the control register that steers the background
	typedef struct packed {
		logic [7:0] scroll_x;
		logic [7:0] scroll_y;
		logic [7:0] ppu_ctrl1;
	} scroll_cfg_t;

	// Where a pixel lives, as seen by the fetch logic
	typedef struct packed {
		vram_addr_t nametable_ptr;
		fine_t      fine_row;
		fine_t      fine_col;
		vram_addr_t pattern_base;
	} tile_loc_t;

	// Nametable 0 starts here, the other three follow at a fixed step
	localparam vram_addr_t NT_BASE = 16'h2000;
	localparam vram_addr_t NT_SIZE = 16'h0400;

	// Second pattern table, the first one sits at address zero
	localparam vram_addr_t PAT_BASE_HI = 16'h1000;
	localparam vram_addr_t PAT_TILE_BYTES = 16'd16;
	localparam vram_addr_t PAT_PLANE_OFS = 16'd8;

	// Size of the four-screen nametable space in pixels
	localparam int unsigned ROW_WRAP = 480;
	localparam int unsigned COL_WRAP = 512;
	localparam int unsigned ROW_NT_OFS = 240;

	// Bits of ppu_ctrl1 that this path looks at
	localparam int unsigned CTRL_ROW_BIT = 1;
	localparam int unsigned CTRL_COL_BIT = 2;
	localparam int unsigned CTRL_PAT_BIT = 4;

endpackage

`default_nettype wire

// File: src/nametable_mapper.sv
// Purely combinational; coord must be a visible pixel (row below 240) for the nametable row to be meaningful
`timescale 1ns/1ns
`default_nettype none

module nametable_mapper (
	input  ppu_bg_pkg::pixel_coord_t coord,
	input  ppu_bg_pkg::scroll_cfg_t  cfg,
	output ppu_bg_pkg::tile_loc_t    loc
);
	import ppu_bg_pkg::*;

	// Ten bits are needed because screen + scroll + nametable offset can reach 766
	logic [9:0] row_sum;
	logic [9:0] col_sum;
	logic [9:0] row_wrap;
	logic [8:0] col_wrap;
	logic       row_half;
	logic       col_half;
	logic [7:0] row_in_nt;
	logic [1:0] nt_index;
	vram_addr_t nt_offset;

	// Row in the nametable space, control bit 1 starts in the lower pair of nametables
	assign row_sum = {2'b00, coord.screen_row} + {2'b00, cfg.scroll_y}
		+ (cfg.ppu_ctrl1[CTRL_ROW_BIT] ? 10'(ROW_NT_OFS) : 10'd0);

	// Column in the nametable space, control bit 2 starts in the right pair
	assign col_sum = {2'b00, coord.screen_col} + {2'b00, cfg.scroll_x}
		+ (cfg.ppu_ctrl1[CTRL_COL_BIT] ? 10'(COL_WRAP / 2) : 10'd0);

	// A single subtract is enough since neither sum reaches twice the wrap size
	assign row_wrap = (row_sum >= 10'(ROW_WRAP)) ? row_sum - 10'(ROW_WRAP) : row_sum;
	assign col_wrap = (col_sum >= 10'(COL_WRAP)) ? 9'(col_sum - 10'(COL_WRAP)) : 9'(col_sum);

	// Rows 240 and up fall in nametables 2 and 3
	assign row_half = (row_wrap >= 10'(ROW_NT_OFS));
	assign col_half = col_wrap[8];

	// Row relative to the top of its own nametable, always 0-239
	assign row_in_nt = row_half ? 8'(row_wrap - 10'(ROW_NT_OFS)) : row_wrap[7:0];

	// Nametables are numbered left to right, then top to bottom
	assign nt_index = {row_half, col_half};

	// Thirty-two tiles per row, so the tile row lands in bits 9:5
	assign nt_offset = {6'b000000, row_in_nt[7:3], 5'b00000} + {11'b0, col_wrap[7:3]};

	always_comb begin
		loc.nametable_ptr = NT_BASE + vram_addr_t'(nt_index) * NT_SIZE + nt_offset;
		// 240 is a multiple of 8, so the fine row survives the half split
		loc.fine_row = row_wrap[2:0];
		loc.fine_col = col_wrap[2:0];
		loc.pattern_base = cfg.ppu_ctrl1[CTRL_PAT_BIT] ? PAT_BASE_HI : '0;
	end

endmodule

`default_nettype wire

// File: bg_fetch/tile_row_cache.sv
// Single entry only; any write to video memory outside this path needs a flush or stale bytes are returned
`timescale 1ns/1ns
`default_nettype none

module tile_row_cache (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   flush,
	input  ppu_bg_pkg::tile_loc_t  loc,
	input  logic                   fill,
	input  ppu_bg_pkg::vram_byte_t fill_lo,
	input  ppu_bg_pkg::vram_byte_t fill_hi,
	output logic                   hit,
	output ppu_bg_pkg::vram_byte_t plane_lo,
	output ppu_bg_pkg::vram_byte_t plane_hi
);
	import ppu_bg_pkg::*;

	// A tile row is identified by where the tile index came from, which row
	// of the tile is wanted and which pattern table it is read from
	typedef struct packed {
		vram_addr_t nametable_ptr;
		fine_t      fine_row;
		vram_addr_t pattern_base;
	} cache_tag_t;

	logic       valid;
	cache_tag_t tag_q;
	cache_tag_t cur_tag;
	vram_byte_t lo_q;
	vram_byte_t hi_q;

	// Fine column is left out so every pixel of the row shares the entry
	always_comb begin
		cur_tag.nametable_ptr = loc.nametable_ptr;
		cur_tag.fine_row = loc.fine_row;
		cur_tag.pattern_base = loc.pattern_base;
	end

	// Lookup happens in the same cycle as the request
	assign hit = valid && (tag_q == cur_tag);
	assign plane_lo = lo_q;
	assign plane_hi = hi_q;

	// Flush takes priority so a fill racing a memory change is dropped
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			valid <= 1'b0;
		end else if (fill) begin
			valid <= 1'b1;
		end
	end

	// The stored row itself, only meaningful while valid is set
	always_ff @(posedge clk) begin
		if (fill && !flush) begin
			tag_q <= cur_tag;
			lo_q <= fill_lo;
			hi_q <= fill_hi;
		end
	end

endmodule

`default_nettype wire

// File: bg_fetch/bg_fetch_ctrl.sv
// One request at a time; pix_adr and scroll settings must stay stable from request to pix_ack
`timescale 1ns/1ns
`default_nettype none

module bg_fetch_ctrl (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     pix_cyc,
	input  logic                     pix_stb,
	output logic                     pix_ack,
	output ppu_bg_pkg::pixel_color_t pix_dat,
	input  ppu_bg_pkg::tile_loc_t    loc,
	input  logic                     hit,
	input  ppu_bg_pkg::vram_byte_t   plane_lo,
	input  ppu_bg_pkg::vram_byte_t   plane_hi,
	output logic                     fill,
	output ppu_bg_pkg::vram_byte_t   fill_lo,
	output ppu_bg_pkg::vram_byte_t   fill_hi,
	output logic                     vram_cyc,
	output logic                     vram_stb,
	output ppu_bg_pkg::vram_addr_t   vram_adr,
	input  logic                     vram_ack,
	input  ppu_bg_pkg::vram_byte_t   vram_dat
);
	import ppu_bg_pkg::*;

	typedef enum logic [2:0] {
		idle,
		read_tile,
		read_lo,
		read_hi,
		respond
	} fetch_state_t;

	fetch_state_t state;
	logic         bus_req;
	logic         req_valid;
	logic         bus_done;
	vram_byte_t   tile_q;
	vram_byte_t   lo_q;
	pixel_color_t color_q;
	vram_addr_t   plane_adr;

	// Bit 7 of a pattern byte is the leftmost pixel of the tile
	function automatic pixel_color_t pick_color(vram_byte_t lo, vram_byte_t hi, fine_t col);
		fine_t bit_idx;
		bit_idx = 3'd7 - col;
		return {hi[bit_idx], lo[bit_idx]};
	endfunction

	assign req_valid = pix_cyc && pix_stb;

	// A read finishes when the slave acks the strobe we are holding
	assign bus_done = bus_req && vram_ack;

	// Low plane byte of the wanted row, the high plane sits eight bytes on
	assign plane_adr = loc.pattern_base + vram_addr_t'(tile_q) * PAT_TILE_BYTES
		+ vram_addr_t'(loc.fine_row);

	always_comb begin
		case (state)
			read_tile: vram_adr = loc.nametable_ptr;
			read_hi: vram_adr = plane_adr + PAT_PLANE_OFS;
			default: vram_adr = plane_adr;
		endcase
	end

	// Cycle and strobe move together since every cycle carries a single read
	assign vram_cyc = bus_req;
	assign vram_stb = bus_req;

	// The cache takes the row on the same edge as the last read completes
	assign fill = (state == read_hi) && bus_done;
	assign fill_lo = lo_q;
	assign fill_hi = vram_dat;

	assign pix_ack = (state == respond);
	assign pix_dat = color_q;

	// The strobe is dropped for one cycle after each ack, then raised again
	// for the next read, so each read is its own bus cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			bus_req <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (req_valid) begin
						if (hit) begin
							state <= respond;
						end else begin
							state <= read_tile;
							bus_req <= 1'b1;
						end
					end
				end
				read_tile: begin
					if (bus_done) begin
						bus_req <= 1'b0;
						state <= read_lo;
					end
				end
				read_lo: begin
					if (!bus_req) begin
						bus_req <= 1'b1;
					end else if (vram_ack) begin
						bus_req <= 1'b0;
						state <= read_hi;
					end
				end
				read_hi: begin
					if (!bus_req) begin
						bus_req <= 1'b1;
					end else if (vram_ack) begin
						bus_req <= 1'b0;
						state <= respond;
					end
				end
				// Ack lasts one cycle, the next request is sampled back in idle
				respond: state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// Fetched bytes and the answer, each captured once per request
	always_ff @(posedge clk) begin
		if (state == idle && req_valid && hit) begin
			color_q <= pick_color(plane_lo, plane_hi, loc.fine_col);
		end
		if (state == read_tile && bus_done) begin
			tile_q <= vram_dat;
		end
		if (state == read_lo && bus_done) begin
			lo_q <= vram_dat;
		end
		if (fill) begin
			color_q <= pick_color(lo_q, vram_dat, loc.fine_col);
		end
	end

endmodule

`default_nettype wire

// File: src/ppu_bg_top.sv
// Background pattern colour only; attributes, palettes, sprites and VRAM mirroring live elsewhere
`timescale 1ns/1ns
`default_nettype none

module ppu_bg_top (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     flush,
	input  ppu_bg_pkg::scroll_cfg_t  cfg,
	input  logic                     pix_cyc,
	input  logic                     pix_stb,
	input  ppu_bg_pkg::pixel_coord_t pix_adr,
	output logic                     pix_ack,
	output ppu_bg_pkg::pixel_color_t pix_dat,
	output logic                     vram_cyc,
	output logic                     vram_stb,
	output ppu_bg_pkg::vram_addr_t   vram_adr,
	input  logic                     vram_ack,
	input  ppu_bg_pkg::vram_byte_t   vram_dat
);
	import ppu_bg_pkg::*;

	tile_loc_t  loc;
	logic       hit;
	vram_byte_t plane_lo;
	vram_byte_t plane_hi;
	logic       fill;
	vram_byte_t fill_lo;
	vram_byte_t fill_hi;

	// Scroll arithmetic straight from the request address
	nametable_mapper u_mapper (
		.coord (pix_adr),
		.cfg   (cfg),
		.loc   (loc)
	);

	// Remembers the last tile row so neighbouring pixels skip the bus
	tile_row_cache u_cache (
		.clk      (clk),
		.reset    (reset),
		.flush    (flush),
		.loc      (loc),
		.fill     (fill),
		.fill_lo  (fill_lo),
		.fill_hi  (fill_hi),
		.hit      (hit),
		.plane_lo (plane_lo),
		.plane_hi (plane_hi)
	);

	// Owns both bus ports and sequences the three reads on a miss
	bg_fetch_ctrl u_ctrl (
		.clk      (clk),
		.reset    (reset),
		.pix_cyc  (pix_cyc),
		.pix_stb  (pix_stb),
		.pix_ack  (pix_ack),
		.pix_dat  (pix_dat),
		.loc      (loc),
		.hit      (hit),
		.plane_lo (plane_lo),
		.plane_hi (plane_hi),
		.fill     (fill),
		.fill_lo  (fill_lo),
		.fill_hi  (fill_hi),
		.vram_cyc (vram_cyc),
		.vram_stb (vram_stb),
		.vram_adr (vram_adr),
		.vram_ack (vram_ack),
		.vram_dat (vram_dat)
	);

endmodule

`default_nettype wire

// File: verification/vram_wb_model.sv
// Read-only Wishbone classic memory for simulation; only 0x0000-0x2FFF hold data and the rest reads as zero
`timescale 1ns/1ns
`default_nettype none

module vram_wb_model (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cyc,
	input  logic                   stb,
	input  ppu_bg_pkg::vram_addr_t adr,
	output logic                   ack,
	output ppu_bg_pkg::vram_byte_t dat
);
	import ppu_bg_pkg::*;

	localparam logic [31:0] SEED = 32'hbeb3;

	vram_byte_t  mem [0:65535];
	logic [31:0] wait_rng;
	logic        busy;
	logic [1:0]  wait_left;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Every byte is a hash of its full address, so no two regions repeat
	function automatic vram_byte_t fill_byte(input int a);
		logic [31:0] h;
		h = xorshift32(SEED ^ (32'(a) * 32'h9e3779b9));
		h = xorshift32(h);
		return h[15:8];
	endfunction

	initial begin
		for (int a = 0; a < 65536; a++) begin
			mem[16'(a)] = (a < 12288) ? fill_byte(a) : 8'h00;
		end
		wait_rng = SEED;
	end

	// Zero to three wait states are drawn when a strobe is first seen
	always @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
			busy <= 1'b0;
			wait_left <= 2'd0;
		end else if (ack) begin
			// The master drops its strobe in the cycle after the ack
			ack <= 1'b0;
		end else if (cyc && stb) begin
			if (busy ? (wait_left == 2'd0) : (wait_rng[1:0] == 2'd0)) begin
				ack <= 1'b1;
				dat <= mem[adr];
				busy <= 1'b0;
			end else if (!busy) begin
				busy <= 1'b1;
				wait_left <= wait_rng[1:0] - 2'd1;
			end else begin
				wait_left <= wait_left - 2'd1;
			end
			if (!busy) begin
				wait_rng <= xorshift32(wait_rng);
			end
		end
	end

endmodule

`default_nettype wire

// File: verification/ppu_bg_tb.sv
// Self-checking testbench; pixels, scroll values and wait states all come from one fixed seed
`timescale 1ns/1ns
`default_nettype none

module ppu_bg_tb;
	import ppu_bg_pkg::*;

	localparam logic [31:0] SEED = 32'hbeb3;
	localparam int RANDOM_REQS = 40;
	localparam int EDGE_REQS = 40;
	// Requests for each of the four nametable control combinations
	localparam int NT_REQS = 8;
	localparam int PAT_REQS = 20;
	localparam int ROW_RUNS = 6;
	localparam int FLUSH_RUNS = 8;
	localparam int TOTAL_REQS = RANDOM_REQS + EDGE_REQS + 4 * NT_REQS + PAT_REQS
		+ ROW_RUNS * 8 + FLUSH_RUNS * 3;
	localparam int CYCLES_PER_REQ = 40;

	logic         clk;
	logic         reset;
	logic         flush;
	scroll_cfg_t  cfg;
	logic         pix_cyc;
	logic         pix_stb;
	pixel_coord_t pix_adr;
	logic         pix_ack;
	pixel_color_t pix_dat;
	logic         vram_cyc;
	logic         vram_stb;
	vram_addr_t   vram_adr;
	logic         vram_ack;
	vram_byte_t   vram_dat;

	logic [31:0]  rng_state;
	vram_byte_t   vram_copy [0:65535];

	// What the one-entry cache should hold, kept from the fetch rules
	logic         cache_valid;
	int           cache_nt;
	int           cache_row;
	int           cache_base;

	ppu_bg_top DUT (
		.clk      (clk),
		.reset    (reset),
		.flush    (flush),
		.cfg      (cfg),
		.pix_cyc  (pix_cyc),
		.pix_stb  (pix_stb),
		.pix_adr  (pix_adr),
		.pix_ack  (pix_ack),
		.pix_dat  (pix_dat),
		.vram_cyc (vram_cyc),
		.vram_stb (vram_stb),
		.vram_adr (vram_adr),
		.vram_ack (vram_ack),
		.vram_dat (vram_dat)
	);

	vram_wb_model vram_mem (
		.clk   (clk),
		.reset (reset),
		.cyc   (vram_cyc),
		.stb   (vram_stb),
		.adr   (vram_adr),
		.ack   (vram_ack),
		.dat   (vram_dat)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic [7:0] random_byte();
		logic [31:0] r;
		r = next_random();
		return r[7:0];
	endfunction

	// Same address hash as the memory model, giving an independent copy
	function automatic vram_byte_t fill_byte(input int a);
		logic [31:0] h;
		h = xorshift32(SEED ^ (32'(a) * 32'h9e3779b9));
		h = xorshift32(h);
		return h[15:8];
	endfunction

	function automatic pixel_coord_t random_coord(input int row_lo, input int row_span,
		input int col_lo, input int col_span);
		pixel_coord_t c;
		c.screen_row = 8'(row_lo + int'(next_random() % 32'(row_span)));
		c.screen_col = 8'(col_lo + int'(next_random() % 32'(col_span)));
		return c;
	endfunction

	// Reference mapping wraps at 480 rows and 512 columns, then splits into
	// four 256x240 nametables of 32 tiles per row
	task automatic map_pixel(input pixel_coord_t coord, input scroll_cfg_t c,
		output int nt_addr, output int fine_row, output int pat_base,
		output pixel_color_t color);
		int row;
		int col;
		int nt;
		int tile;
		int pat_addr;
		int lo;
		int hi;
		int bit_idx;
		row = int'(coord.screen_row) + int'(c.scroll_y);
		if (c.ppu_ctrl1[1]) begin
			row = row + 240;
		end
		row = row % 480;
		col = int'(coord.screen_col) + int'(c.scroll_x);
		if (c.ppu_ctrl1[2]) begin
			col = col + 256;
		end
		col = col % 512;
		nt = (row / 240) * 2 + col / 256;
		nt_addr = 'h2000 + nt * 'h400 + ((row % 240) / 8) * 32 + (col % 256) / 8;
		tile = int'(vram_copy[16'(nt_addr)]);
		pat_base = c.ppu_ctrl1[4] ? 'h1000 : 0;
		fine_row = row % 8;
		pat_addr = pat_base + tile * 16 + fine_row;
		lo = int'(vram_copy[16'(pat_addr)]);
		hi = int'(vram_copy[16'(pat_addr + 8)]);
		// Leftmost pixel sits in bit 7
		bit_idx = 7 - col % 8;
		color = pixel_color_t'(((hi >> bit_idx) & 1) * 2 + ((lo >> bit_idx) & 1));
	endtask

	task automatic check_color(input pixel_color_t got, input pixel_color_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: pixel colour %0d, expected %0d", $time, got, exp);
			$display("test failed");
			$fatal(1, "pixel colour mismatch");
		end
	endtask

	task automatic check_vram_reads(input int got, input int exp);
		if (got != exp) begin
			$display("ERROR at %0t ns: %0d video memory reads, expected %0d", $time, got, exp);
			$display("test failed");
			$fatal(1, "video memory read count mismatch");
		end
	endtask

	task automatic check_vram_addr(input vram_addr_t got, input vram_addr_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: nametable read at %h, expected %h", $time, got, exp);
			$display("test failed");
			$fatal(1, "nametable address mismatch");
		end
	endtask

	task automatic check_ack_latency(input int got, input int exp);
		if (got != exp) begin
			$display("ERROR at %0t ns: ack after %0d cycles, expected %0d", $time, got, exp);
			$display("test failed");
			$fatal(1, "hit latency mismatch");
		end
	endtask

	task automatic set_config(input logic [7:0] sx, input logic [7:0] sy,
		input logic [7:0] ctrl);
		@(negedge clk);
		cfg.scroll_x = sx;
		cfg.scroll_y = sy;
		cfg.ppu_ctrl1 = ctrl;
	endtask

	task automatic pulse_flush();
		@(negedge clk);
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		cache_valid = 1'b0;
	endtask

	// One full request from driving the address until the pixel ack
	task automatic run_pixel(input pixel_coord_t coord);
		int           nt_addr;
		int           fine_row;
		int           pat_base;
		pixel_color_t exp_color;
		pixel_color_t got_color;
		logic         exp_hit;
		int           cycles;
		int           reads;
		int           strobes;
		logic         prev_cyc;
		logic         prev_stb;
		logic         got_ack;
		vram_addr_t   first_adr;
		map_pixel(coord, cfg, nt_addr, fine_row, pat_base, exp_color);
		exp_hit = cache_valid && (cache_nt == nt_addr) && (cache_row == fine_row)
			&& (cache_base == pat_base);
		@(negedge clk);
		pix_adr = coord;
		pix_cyc = 1'b1;
		pix_stb = 1'b1;
		cycles = 0;
		reads = 0;
		strobes = 0;
		prev_cyc = 1'b0;
		prev_stb = 1'b0;
		got_ack = 1'b0;
		first_adr = '0;
		while (!got_ack) begin
			@(negedge clk);
			cycles++;
			// A new bus cycle starts each time vram_cyc goes high
			if (vram_cyc && !prev_cyc) begin
				reads++;
				if (reads == 1) begin
					first_adr = vram_adr;
				end
			end
			// Every read carries its own strobe as well
			if (vram_stb && !prev_stb) begin
				strobes++;
			end
			prev_cyc = vram_cyc;
			prev_stb = vram_stb;
			got_ack = pix_ack;
		end
		got_color = pix_dat;
		pix_cyc = 1'b0;
		pix_stb = 1'b0;
		check_color(got_color, exp_color);
		check_vram_reads(reads, exp_hit ? 0 : 3);
		check_vram_reads(strobes, exp_hit ? 0 : 3);
		if (exp_hit) begin
			check_ack_latency(cycles, 1);
		end else begin
			check_vram_addr(first_adr, vram_addr_t'(nt_addr));
			cache_valid = 1'b1;
			cache_nt = nt_addr;
			cache_row = fine_row;
			cache_base = pat_base;
		end
	endtask

	initial begin
		pixel_coord_t coord;
		logic [7:0]   col_start;
		reset = 1'b1;
		flush = 1'b0;
		cfg = '0;
		pix_cyc = 1'b0;
		pix_stb = 1'b0;
		pix_adr = '0;
		rng_state = SEED;
		cache_valid = 1'b0;
		cache_nt = 0;
		cache_row = 0;
		cache_base = 0;
		for (int a = 0; a < 65536; a++) begin
			vram_copy[16'(a)] = (a < 12288) ? fill_byte(a) : 8'h00;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// No scroll, all control bits clear, pixels anywhere on screen
		set_config(8'h00, 8'h00, 8'h00);
		for (int i = 0; i < RANDOM_REQS; i++) begin
			run_pixel(random_coord(0, 240, 0, 256));
		end

		// Bottom and right edge pixels under random scroll force the wrap
		for (int i = 0; i < EDGE_REQS; i++) begin
			if (i % 8 == 0) begin
				set_config(random_byte(), random_byte(), 8'h00);
			end
			run_pixel(random_coord(200, 40, 200, 56));
		end

		// All four combinations of the row and column nametable bits
		for (int combo = 0; combo < 4; combo++) begin
			set_config(random_byte(), random_byte(), 8'(combo << 1));
			for (int i = 0; i < NT_REQS; i++) begin
				run_pixel(random_coord(0, 240, 0, 256));
			end
		end

		// Second pattern table
		for (int i = 0; i < PAT_REQS; i++) begin
			if (i % 5 == 0) begin
				set_config(random_byte(), random_byte(), 8'h10 | (random_byte() & 8'h06));
			end
			run_pixel(random_coord(0, 240, 0, 256));
		end

		// Eight pixels of one tile row, tile aligned, so seven of them must hit
		for (int r = 0; r < ROW_RUNS; r++) begin
			set_config(random_byte() & 8'hf8, random_byte(), random_byte() & 8'h16);
			coord = random_coord(0, 240, 0, 256);
			col_start = coord.screen_col & 8'hf8;
			for (int k = 0; k < 8; k++) begin
				coord.screen_col = col_start + 8'(k);
				run_pixel(coord);
			end
		end

		// Fetch, hit, then flush and the same pixel goes to memory again
		for (int f = 0; f < FLUSH_RUNS; f++) begin
			set_config(random_byte(), random_byte(), random_byte() & 8'h16);
			coord = random_coord(0, 240, 0, 256);
			run_pixel(coord);
			run_pixel(coord);
			pulse_flush();
			run_pixel(coord);
		end

		$display("test passed");
		$finish;
	end

	// Budget covers the slowest miss with every read at maximum wait states
	initial begin
		repeat (TOTAL_REQS * CYCLES_PER_REQ + 100) @(posedge clk);
		$display("Watchdog expired: the DUT stopped answering pixel requests");
		$display("test failed");
		$fatal(1, "simulation hung");
	end

endmodule

`default_nettype wire

// File: src.f
common/ppu_bg_pkg.sv
src/nametable_mapper.sv
bg_fetch/tile_row_cache.sv
bg_fetch/bg_fetch_ctrl.sv
src/ppu_bg_top.sv
verification/vram_wb_model.sv
verification/ppu_bg_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the background tile path testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns -j 0 \
	--top-module ppu_bg_tb -Mdir "$BUILD_DIR" -f src.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vppu_bg_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "^test passed$" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi
